// File: Makefile
# Verilator build and run of the Ethernet MAC testbench
TOP := eth_mac_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: rtl/eth_crc32.sv
`timescale 1ns/1ps

/*
 * Byte-serial Ethernet CRC-32 register (reflected polynomial, LSB first).
 * init reloads all ones, update folds in one data byte per cycle.
 */
module eth_crc32 (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  logic        init,
    input  logic        update,
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            r = (r[0] ^ d[i]) ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            crc <= '1;
        end else if (init) begin
            crc <= '1;
        end else if (update) begin
            crc <= crc_byte(crc, data);
        end
    end

endmodule

// File: rtl/eth_frame_fifo.sv
`timescale 1ns/1ps

/*
 * Store-and-forward byte FIFO. A frame becomes readable only once its last
 * byte is in; frames flagged bad by user, or that meet a full FIFO, are
 * rolled back. One-cycle status pulses report each frame's fate.
 */
module eth_frame_fifo #(
    parameter int addr_width = eth_pkg::fifo_addr_width
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    input  logic       in_last,
    input  logic       in_user,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    input  logic       out_ready,
    output logic       good_frame,
    output logic       bad_frame,
    output logic       overflow
);

    // Each entry holds {last, data}
    logic [8:0]          mem [2**addr_width];
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_commit;
    logic [addr_width:0] rd_ptr;
    logic                drop_frame;
    logic                full;
    logic                in_xfer;

    assign full = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                  (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // In drop mode bytes are swallowed until last
    assign in_ready = !full || drop_frame;
    assign in_xfer  = in_valid && in_ready;

    always_ff @(posedge logic_clk) begin
        if (in_xfer && !drop_frame) begin
            mem[wr_ptr[addr_width-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            wr_commit  <= '0;
            drop_frame <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (in_valid && full && !drop_frame) begin
                // Frame does not fit, discard what was written so far
                drop_frame <= 1'b1;
                wr_ptr     <= wr_commit;
            end else if (in_xfer) begin
                if (!drop_frame) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (in_last) begin
                    if (drop_frame) begin
                        overflow   <= 1'b1;
                        drop_frame <= 1'b0;
                    end else if (in_user) begin
                        bad_frame <= 1'b1;
                        wr_ptr    <= wr_commit;
                    end else begin
                        good_frame <= 1'b1;
                        wr_commit  <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    // Read side sees committed bytes only
    assign out_valid            = (rd_ptr != wr_commit);
    assign {out_last, out_data} = mem[rd_ptr[addr_width-1:0]];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: rtl/eth_mac_fifo.sv
`timescale 1ns/1ps

/*
 * Byte-wide Ethernet MAC with a frame FIFO on each side. User frames go
 * through the TX FIFO to the GMII transmitter; received frames go from the
 * deframer through the RX FIFO, which drops bad and oversized frames.
 */
module eth_mac_fifo (
    input  logic               logic_clk,
    input  logic               logic_rst,
    input  logic [7:0]         tx_axis_data,
    input  logic               tx_axis_valid,
    output logic               tx_axis_ready,
    input  logic               tx_axis_last,
    input  logic               tx_axis_user,
    output logic [7:0]         rx_axis_data,
    output logic               rx_axis_valid,
    input  logic               rx_axis_ready,
    output logic               rx_axis_last,
    output logic               rx_axis_user,
    output logic [7:0]         gmii_txd,
    output logic               gmii_tx_en,
    input  logic [7:0]         gmii_rxd,
    input  logic               gmii_rx_dv,
    output logic               tx_fifo_overflow,
    output logic               tx_fifo_bad_frame,
    output logic               tx_fifo_good_frame,
    output logic               rx_error_bad_frame,
    output logic               rx_error_bad_fcs,
    output logic               rx_fifo_overflow,
    output logic               rx_fifo_bad_frame,
    output logic               rx_fifo_good_frame,
    input  logic [7:0]         ifg_delay,
    output eth_pkg::tx_state_t tx_state
);

    logic [7:0] tx_fifo_data;
    logic       tx_fifo_valid;
    logic       tx_fifo_ready;
    logic       tx_fifo_last;

    logic [7:0] rx_fifo_data;
    logic       rx_fifo_valid;
    logic       rx_fifo_last;
    logic       rx_fifo_user;

    // Bad frames never leave the RX FIFO
    assign rx_axis_user = 1'b0;

    eth_frame_fifo tx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_data    (tx_axis_data),
        .in_valid   (tx_axis_valid),
        .in_last    (tx_axis_last),
        .in_user    (tx_axis_user),
        .in_ready   (tx_axis_ready),
        .out_data   (tx_fifo_data),
        .out_valid  (tx_fifo_valid),
        .out_last   (tx_fifo_last),
        .out_ready  (tx_fifo_ready),
        .good_frame (tx_fifo_good_frame),
        .bad_frame  (tx_fifo_bad_frame),
        .overflow   (tx_fifo_overflow)
    );

    eth_tx_ctrl tx_ctrl (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .ifg_delay  (ifg_delay),
        .fifo_data  (tx_fifo_data),
        .fifo_valid (tx_fifo_valid),
        .fifo_last  (tx_fifo_last),
        .fifo_ready (tx_fifo_ready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .state      (tx_state)
    );

    eth_rx_parser rx_parser (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .out_data           (rx_fifo_data),
        .out_valid          (rx_fifo_valid),
        .out_last           (rx_fifo_last),
        .out_user           (rx_fifo_user),
        .rx_error_bad_fcs   (rx_error_bad_fcs),
        .rx_error_bad_frame (rx_error_bad_frame)
    );

    // The receive line cannot stall, so the RX FIFO ready is not used
    eth_frame_fifo rx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_data    (rx_fifo_data),
        .in_valid   (rx_fifo_valid),
        .in_last    (rx_fifo_last),
        .in_user    (rx_fifo_user),
        .in_ready   (),
        .out_data   (rx_axis_data),
        .out_valid  (rx_axis_valid),
        .out_last   (rx_axis_last),
        .out_ready  (rx_axis_ready),
        .good_frame (rx_fifo_good_frame),
        .bad_frame  (rx_fifo_bad_frame),
        .overflow   (rx_fifo_overflow)
    );

endmodule

// File: rtl/eth_pkg.sv
/*
 * Shared constants and state types for the byte-wide Ethernet MAC.
 * Modules import it inside their bodies; port lists use scoped names.
 */
package eth_pkg;

    // Frame layout
    localparam int          min_payload   = 60;
    localparam int          preamble_len  = 7;
    localparam logic [7:0]  sfd_byte      = 8'hd5;
    localparam logic [7:0]  preamble_byte = 8'h55;

    // CRC register after a good frame plus its FCS, reflected form
    localparam logic [31:0] crc_residue   = 32'hdebb20e3;

    // 128-byte frame FIFOs by default
    localparam int          fifo_addr_width = 7;

    // Smallest gap between frames in byte times
    localparam int          min_ifg       = 12;

    typedef enum logic [2:0] {
        tx_idle, tx_preamble, tx_sfd, tx_payload, tx_pad, tx_fcs, tx_gap
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_hunt, rx_payload, rx_drop
    } rx_state_t;

endpackage

// File: rtl/eth_rx_parser.sv
`timescale 1ns/1ps

/*
 * GMII receive deframer. Hunts for the SFD, strips preamble and FCS and
 * checks the CRC. The line cannot be stalled, so the output is a plain
 * valid stream with user set on the last byte of a frame with a bad FCS.
 */
module eth_rx_parser (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    output logic       out_user,
    output logic       rx_error_bad_fcs,
    output logic       rx_error_bad_frame
);
    import eth_pkg::*;

    rx_state_t   state;
    logic [2:0]  cnt;
    logic [7:0]  sr [5];
    logic [31:0] crc;
    logic        crc_bad;

    eth_crc32 crc_inst (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .init      (state == rx_hunt),
        .update    (state == rx_payload && gmii_rx_dv),
        .data      (gmii_rxd),
        .crc       (crc)
    );

    assign crc_bad = (crc != crc_residue);

    // Five bytes held back: the four FCS bytes plus the pending data byte
    always_ff @(posedge logic_clk) begin
        if (state == rx_payload) begin
            out_data <= sr[0];
            if (gmii_rx_dv) begin
                for (int i = 0; i < 4; i++) begin
                    sr[i] <= sr[i+1];
                end
                sr[4] <= gmii_rxd;
            end
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state              <= rx_hunt;
            cnt                <= '0;
            out_valid          <= 1'b0;
            out_last           <= 1'b0;
            out_user           <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
            rx_error_bad_frame <= 1'b0;
        end else begin
            out_valid          <= 1'b0;
            out_last           <= 1'b0;
            out_user           <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            case (state)
                rx_hunt: begin
                    cnt <= '0;
                    if (gmii_rx_dv && gmii_rxd == sfd_byte) begin
                        state <= rx_payload;
                    end else if (gmii_rx_dv && gmii_rxd != preamble_byte) begin
                        state <= rx_drop;
                    end
                end
                rx_payload: begin
                    if (gmii_rx_dv) begin
                        // Oldest byte has five behind it, so it is not last
                        if (cnt == 3'd5) begin
                            out_valid <= 1'b1;
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    end else begin
                        state <= rx_hunt;
                        if (cnt == 3'd5) begin
                            out_valid        <= 1'b1;
                            out_last         <= 1'b1;
                            out_user         <= crc_bad;
                            rx_error_bad_fcs <= crc_bad;
                        end else begin
                            rx_error_bad_frame <= 1'b1;
                        end
                    end
                end
                rx_drop: begin
                    if (!gmii_rx_dv) begin
                        state <= rx_hunt;
                    end
                end
                default: state <= rx_hunt;
            endcase
        end
    end

endmodule

// File: rtl/eth_tx_ctrl.sv
`timescale 1ns/1ps

/*
 * GMII transmit controller. Pulls one committed frame from the TX FIFO and
 * sends preamble, SFD, payload, zero padding and FCS, then keeps tx_en low
 * for the inter-frame gap before looking for the next frame.
 */
module eth_tx_ctrl (
    input  logic               logic_clk,
    input  logic               logic_rst,
    input  logic [7:0]         ifg_delay,
    input  logic [7:0]         fifo_data,
    input  logic               fifo_valid,
    input  logic               fifo_last,
    output logic               fifo_ready,
    output logic [7:0]         gmii_txd,
    output logic               gmii_tx_en,
    output eth_pkg::tx_state_t state
);
    import eth_pkg::*;

    logic [7:0]  cnt;
    logic [7:0]  ifg;
    logic        crc_init;
    logic        crc_update;
    logic [7:0]  crc_data;
    logic [31:0] crc;

    // Programmed gap, raised to the standard minimum
    assign ifg = (ifg_delay < 8'(min_ifg)) ? 8'(min_ifg) : ifg_delay;

    // Payload bytes are taken one per cycle in sfd and payload
    assign fifo_ready = (state == tx_sfd) || (state == tx_payload);
    assign crc_init   = (state == tx_idle);
    assign crc_update = fifo_ready || (state == tx_pad);
    assign crc_data   = (state == tx_pad) ? 8'h00 : fifo_data;

    eth_crc32 crc_inst (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .init      (crc_init),
        .update    (crc_update),
        .data      (crc_data),
        .crc       (crc)
    );

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= tx_idle;
            cnt        <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                tx_idle: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    if (fifo_valid) begin
                        gmii_txd   <= preamble_byte;
                        gmii_tx_en <= 1'b1;
                        cnt        <= 8'd1;
                        state      <= tx_preamble;
                    end
                end
                tx_preamble: begin
                    if (cnt < 8'(preamble_len)) begin
                        gmii_txd <= preamble_byte;
                        cnt      <= cnt + 8'd1;
                    end else begin
                        gmii_txd <= sfd_byte;
                        cnt      <= '0;
                        state    <= tx_sfd;
                    end
                end
                tx_sfd, tx_payload: begin
                    // cnt counts data bytes and saturates on long frames
                    gmii_txd <= fifo_data;
                    state    <= tx_payload;
                    if (cnt != 8'hff) begin
                        cnt <= cnt + 8'd1;
                    end
                    if (fifo_last) begin
                        if (cnt < 8'(min_payload - 1)) begin
                            state <= tx_pad;
                        end else begin
                            cnt   <= '0;
                            state <= tx_fcs;
                        end
                    end
                end
                tx_pad: begin
                    gmii_txd <= 8'h00;
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'(min_payload - 1)) begin
                        cnt   <= '0;
                        state <= tx_fcs;
                    end
                end
                tx_fcs: begin
                    // Complemented CRC, low byte first
                    gmii_txd <= ~crc[{cnt[1:0], 3'b000} +: 8];
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'd3) begin
                        cnt   <= '0;
                        state <= tx_gap;
                    end
                end
                tx_gap: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    cnt        <= cnt + 8'd1;
                    if (cnt >= ifg - 8'd1) begin
                        cnt   <= '0;
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// File: tests/eth_mac_checker.sv
`timescale 1ns/1ps

/*
 * Scoreboard for the MAC testbench. Builds the expected receive frames and
 * status counts from the pattern words, then compares rx_axis byte by byte,
 * checks the gap and the TX state at the edges of gmii_tx_en, and checks
 * the counts when the test ends.
 */
module eth_mac_checker #(
    parameter int depth = 256
) (
    input  logic               logic_clk,
    input  logic               logic_rst,
    input  logic [11:0]        patterns [depth],
    input  logic [7:0]         ifg_delay,
    input  logic               gmii_tx_en,
    input  eth_pkg::tx_state_t tx_state,
    input  logic [7:0]         rx_axis_data,
    input  logic               rx_axis_valid,
    input  logic               rx_axis_ready,
    input  logic               rx_axis_last,
    input  logic               rx_axis_user,
    input  logic               tx_fifo_good_frame,
    input  logic               tx_fifo_bad_frame,
    input  logic               tx_fifo_overflow,
    input  logic               rx_error_bad_fcs,
    input  logic               rx_error_bad_frame,
    input  logic               rx_fifo_good_frame,
    input  logic               rx_fifo_bad_frame,
    input  logic               rx_fifo_overflow,
    input  logic               end_of_test,
    output logic               all_received,
    output logic               final_done,
    output int                 error_count,
    output int                 frame_count
);
    import eth_pkg::*;

    logic [8:0] expected [$];
    logic [7:0] status;
    int         seen [8];
    int         want [8];
    int         wire_frames;
    int         exp_frames;
    int         gap;
    logic       built;
    logic       tx_en_d;
    string      names [8] = '{"tx_fifo_good_frame", "tx_fifo_bad_frame", "tx_fifo_overflow",
                              "rx_error_bad_fcs", "rx_error_bad_frame", "rx_fifo_good_frame",
                              "rx_fifo_bad_frame", "rx_fifo_overflow"};

    assign status = {rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame,
                     rx_error_bad_frame, rx_error_bad_fcs, tx_fifo_overflow,
                     tx_fifo_bad_frame, tx_fifo_good_frame};
    assign all_received = built && (frame_count == exp_frames);

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        error_count++;
        $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    endtask

    // Good frames are expected padded, user and corrupt frames are dropped
    task automatic build_expected();
        logic [7:0] frame [$];
        int         last_idx;
        for (int i = 0; i < depth && !patterns[i][8]; i++) begin
            frame.push_back(patterns[i][7:0]);
            if (patterns[i][9]) begin
                if (patterns[i][10]) begin
                    want[1]++;
                end else if (patterns[i][11]) begin
                    want[0]++;
                    want[3]++;
                    want[6]++;
                end else begin
                    want[0]++;
                    want[5]++;
                    exp_frames++;
                    while (frame.size() < min_payload) begin
                        frame.push_back(8'h00);
                    end
                    last_idx = frame.size() - 1;
                    foreach (frame[j]) begin
                        expected.push_back({j == last_idx, frame[j]});
                    end
                end
                frame.delete();
            end
        end
    endtask

    // Everything is sampled mid-cycle, where DUT outputs and tb drives are stable
    always @(negedge logic_clk) begin
        logic [8:0] exp_word;
        int         need_gap;
        if (logic_rst) begin
            built       = 1'b0;
            final_done  = 1'b0;
            tx_en_d     = 1'b0;
            error_count = 0;
            frame_count = 0;
            wire_frames = 0;
            exp_frames  = 0;
            gap         = 0;
            for (int k = 0; k < 8; k++) begin
                seen[k] = 0;
                want[k] = 0;
            end
        end else begin
            if (!built) begin
                build_expected();
                built = 1'b1;
            end
            for (int k = 0; k < 8; k++) begin
                if (status[k]) begin
                    seen[k]++;
                end
            end

            // Idle time between frames on the transmit pins
            need_gap = (ifg_delay > min_ifg) ? int'(ifg_delay) : min_ifg;
            if (gmii_tx_en && !tx_en_d) begin
                if (tx_state !== tx_preamble) begin
                    report("tx_state at frame start", tx_preamble, tx_state);
                end
                if (wire_frames > 0 && gap < need_gap) begin
                    report("ifg", need_gap, gap);
                end
                wire_frames++;
            end
            if (!gmii_tx_en && tx_en_d && tx_state !== tx_gap) begin
                report("tx_state after frame", tx_gap, tx_state);
            end
            gap     = gmii_tx_en ? 0 : gap + 1;
            tx_en_d = gmii_tx_en;

            if (rx_axis_valid && rx_axis_ready) begin
                if (expected.size() == 0) begin
                    error_count++;
                    $display("Byte 0x%0h arrived on rx_axis with no frame pending", rx_axis_data);
                end else begin
                    exp_word = expected.pop_front();
                    if (rx_axis_data !== exp_word[7:0]) begin
                        report($sformatf("rx frame %0d data", frame_count), exp_word[7:0],
                               rx_axis_data);
                    end
                    if (rx_axis_last !== exp_word[8]) begin
                        report($sformatf("rx frame %0d last", frame_count), exp_word[8],
                               rx_axis_last);
                    end
                    if (rx_axis_user !== 1'b0) begin
                        report($sformatf("rx frame %0d user", frame_count), 0, rx_axis_user);
                    end
                end
                if (rx_axis_last) begin
                    frame_count++;
                end
            end

            if (end_of_test && !final_done) begin
                for (int k = 0; k < 8; k++) begin
                    if (seen[k] != want[k]) begin
                        report(names[k], want[k], seen[k]);
                    end
                end
                if (wire_frames != want[0]) begin
                    report("gmii frames", want[0], wire_frames);
                end
                if (expected.size() != 0) begin
                    error_count++;
                    $display("%0d expected bytes never arrived on rx_axis", expected.size());
                end
                final_done = 1'b1;
            end
        end
    end

endmodule

// File: tests/eth_mac_tb.sv
`timescale 1ns/1ps

/*
 * Testbench for the Ethernet MAC. Sends the frames of the pattern file into
 * tx_axis, loops GMII transmit back to receive with optional corruption,
 * applies random rx_axis back-pressure and lets the checker score the run.
 */
module eth_mac_tb;
    import eth_pkg::*;

    localparam int depth = 256;

    logic        logic_clk;
    logic        logic_rst;
    logic [7:0]  tx_axis_data;
    logic        tx_axis_valid;
    logic        tx_axis_ready;
    logic        tx_axis_last;
    logic        tx_axis_user;
    logic [7:0]  rx_axis_data;
    logic        rx_axis_valid;
    logic        rx_axis_ready = 1'b1;
    logic        rx_axis_last;
    logic        rx_axis_user;
    logic [7:0]  gmii_txd;
    logic        gmii_tx_en;
    logic [7:0]  gmii_rxd = 8'h00;
    logic        gmii_rx_dv = 1'b0;
    logic        tx_fifo_overflow;
    logic        tx_fifo_bad_frame;
    logic        tx_fifo_good_frame;
    logic        rx_error_bad_frame;
    logic        rx_error_bad_fcs;
    logic        rx_fifo_overflow;
    logic        rx_fifo_bad_frame;
    logic        rx_fifo_good_frame;
    logic [7:0]  ifg_delay;
    tx_state_t   tx_state;

    logic [11:0] patterns [depth];
    logic        wire_corrupt [$];
    logic [31:0] lcg_state = 32'h1c91_60c4;
    logic        end_of_test;
    logic        all_received;
    logic        final_done;
    int          error_count;
    int          frame_count;
    int          wire_frame = 0;
    int          wire_idx = 0;
    int          cycles = 0;
    int          limit = 0;

    eth_mac_fifo DUT (.*);

    eth_mac_checker #(.depth(depth)) chk (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        logic_clk = 1'b0;
        forever #5 logic_clk = ~logic_clk;
    end

    // Ready low in about one cycle of four
    always @(posedge logic_clk) begin
        #1;
        lcg_state     = lcg_next(lcg_state);
        rx_axis_ready = (lcg_state[31:30] != 2'b00);
    end

    // Loopback; wire byte 12 is the fifth payload byte after preamble and SFD
    always @(posedge logic_clk) begin
        #1;
        gmii_rx_dv = gmii_tx_en;
        gmii_rxd   = gmii_txd;
        if (gmii_tx_en) begin
            if (wire_idx == 12 && wire_frame < wire_corrupt.size() &&
                wire_corrupt[wire_frame]) begin
                gmii_rxd = ~gmii_txd;
            end
            wire_idx++;
        end else if (wire_idx != 0) begin
            wire_idx = 0;
            wire_frame++;
        end
    end

    always @(posedge logic_clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles with frames still outstanding", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic send_word(input logic [11:0] w);
        tx_axis_data  = w[7:0];
        tx_axis_last  = w[9];
        tx_axis_user  = w[10];
        tx_axis_valid = 1'b1;
        while (!tx_axis_ready) begin
            @(posedge logic_clk);
            #1;
        end
        @(posedge logic_clk);
        #1;
        tx_axis_valid = 1'b0;
    endtask

    // Every byte of the frame has left the TX FIFO once the FCS starts
    task automatic wait_tx_drained();
        while (tx_state != tx_fcs) begin
            @(posedge logic_clk);
            #1;
        end
    endtask

    initial begin
        int frame_total;
        tx_axis_data  = 8'h00;
        tx_axis_valid = 1'b0;
        tx_axis_last  = 1'b0;
        tx_axis_user  = 1'b0;
        ifg_delay     = 8'd16;
        end_of_test   = 1'b0;
        logic_rst     = 1'b1;
        frame_total   = 0;
        $readmemh("tests/eth_patterns.mem", patterns);
        for (int i = 0; i < depth && !patterns[i][8]; i++) begin
            if (patterns[i][9]) begin
                frame_total++;
                if (!patterns[i][10]) begin
                    wire_corrupt.push_back(patterns[i][11]);
                end
            end
        end
        limit = 200 * frame_total + 100;

        repeat (5) @(posedge logic_clk);
        #1;
        logic_rst = 1'b0;

        for (int i = 0; i < depth && !patterns[i][8]; i++) begin
            send_word(patterns[i]);
            if (patterns[i][9] && !patterns[i][10]) begin
                wait_tx_drained();
            end
        end

        while (!all_received) begin
            @(posedge logic_clk);
            #1;
        end
        // Transmitter back in idle after the last gap
        while (tx_state != tx_idle) begin
            @(posedge logic_clk);
            #1;
        end
        end_of_test = 1'b1;
        while (!final_done) begin
            @(posedge logic_clk);
            #1;
        end

        $display("Frames received: %0d, errors: %0d", frame_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tests/eth_patterns.mem
// Columns: bit 11 corrupt on the wire, bit 10 user (bad frame), bit 9 last,
// bits 7..0 data byte. A word with bit 8 set ends the list.
// Frame 0: good, 64 bytes
000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f
010 011 012 013 014 015 016 017 018 019 01a 01b 01c 01d 01e 01f
020 021 022 023 024 025 026 027 028 029 02a 02b 02c 02d 02e 02f
030 031 032 033 034 035 036 037 038 039 03a 03b 03c 03d 03e 23f
// Frame 1: good, 10 bytes, padded on the wire
0a0 0a1 0a2 0a3 0a4 0a5 0a6 0a7 0a8 2a9
// Frame 2: user flag on the last byte, never sent
0b0 0b1 0b2 0b3 0b4 0b5 0b6 6b7
// Frame 3: 20 bytes, corrupted on the wire
0c0 0c1 0c2 0c3 0c4 0c5 0c6 0c7 0c8 0c9 0ca 0cb 0cc 0cd 0ce 0cf
0d0 0d1 0d2 ad3
// Frame 4: good, 16 bytes
0e0 0e1 0e2 0e3 0e4 0e5 0e6 0e7 0e8 0e9 0ea 0eb 0ec 0ed 0ee 2ef
// Frame 5: good, 80 bytes
040 041 042 043 044 045 046 047 048 049 04a 04b 04c 04d 04e 04f
050 051 052 053 054 055 056 057 058 059 05a 05b 05c 05d 05e 05f
060 061 062 063 064 065 066 067 068 069 06a 06b 06c 06d 06e 06f
070 071 072 073 074 075 076 077 078 079 07a 07b 07c 07d 07e 07f
080 081 082 083 084 085 086 087 088 089 08a 08b 08c 08d 08e 28f
100

// File: verilog.f
rtl/eth_pkg.sv
rtl/eth_crc32.sv
rtl/eth_frame_fifo.sv
rtl/eth_tx_ctrl.sv
rtl/eth_rx_parser.sv
rtl/eth_mac_fifo.sv
tests/eth_mac_checker.sv
tests/eth_mac_tb.sv
